//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = exCoreTb
FILELIST  = files.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation passed

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- files.f
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/regFile.sv
src/forwardingUnit.sv
src/alu.sv
src/exStage.sv
src/pipeRegs.sv
src/exCore.sv
tb/exCoreChecker.sv
tb/exCoreTb.sv

//--- src/alu.sv
`timescale 1ns/1ps
`include "exCore_params.svh"

module alu import isaPkg::*; (
    input  word  a,
    input  word  b,
    input  aluOp aluControl,
    output word  result,
    output logic zero
);

    logic [4:0] shamt;
    logic       lessThan;

    // Shifts use only the low five bits of b
    assign shamt    = b[4:0];
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluControl)
            `ALU_ADD: result = a + b;
            `ALU_SUB: result = a - b;
            `ALU_AND: result = a & b;
            `ALU_OR:  result = a | b;
            `ALU_XOR: result = a ^ b;
            `ALU_SLL: result = a << shamt;
            `ALU_SRL: result = a >> shamt;
            `ALU_SRA: result = word'($signed(a) >>> shamt);
            `ALU_SLT: result = {{(`XLEN-1){1'b0}}, lessThan};
            // Unused codes produce zero
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- src/exCore.sv
`timescale 1ns/1ps

module exCore import isaPkg::*, pipePkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   issue,
    input  regAddr rs1,
    input  regAddr rs2,
    input  regAddr rd,
    input  word    imm,
    input  word    pc,
    input  aluOp   aluControl,
    input  logic   aluSrc,
    input  logic   regWrite,
    output logic   wbValid,
    output regAddr wbRd,
    output word    wbData,
    output logic   wbZero,
    output word    wbTAddr
);

    // Decode read data
    word    rdData1;
    word    rdData2;

    // ID/EX fields
    regAddr exRs1;
    regAddr exRs2;
    word    exImm;
    word    exPc;
    word    exRd1;
    word    exRd2;
    aluOp   exAluControl;
    logic   exAluSrc;

    // Execute results
    word    exResult;
    logic   exZero;
    word    exTAddr;
    word    exStoreData;

    // Later stages
    regAddr memRd;
    logic   memRegWrite;
    word    memResult;
    logic   wbRegWrite;
    fwdSel  forwardA;
    fwdSel  forwardB;

    regFile rf_i (
        .clk     (clk),
        .rst     (rst),
        .rdAddr1 (rs1),
        .rdAddr2 (rs2),
        .wrEn    (wbRegWrite),
        .wrAddr  (wbRd),
        .wrData  (wbData),
        .rdData1 (rdData1),
        .rdData2 (rdData2)
    );

    pipeRegs pipe_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .pc           (pc),
        .aluControl   (aluControl),
        .aluSrc       (aluSrc),
        .regWrite     (regWrite),
        .rdData1      (rdData1),
        .rdData2      (rdData2),
        .exResult     (exResult),
        .exZero       (exZero),
        .exTAddr      (exTAddr),
        .exStoreData  (exStoreData),
        .exRs1        (exRs1),
        .exRs2        (exRs2),
        .exImm        (exImm),
        .exPc         (exPc),
        .exRd1        (exRd1),
        .exRd2        (exRd2),
        .exAluControl (exAluControl),
        .exAluSrc     (exAluSrc),
        .memRd        (memRd),
        .memRegWrite  (memRegWrite),
        .memResult    (memResult),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbRegWrite   (wbRegWrite),
        .wbData       (wbData),
        .wbZero       (wbZero),
        .wbTAddr      (wbTAddr)
    );

    forwardingUnit fwd_i (
        .exRs1       (exRs1),
        .exRs2       (exRs2),
        .memRd       (memRd),
        .wbRd        (wbRd),
        .memRegWrite (memRegWrite),
        .wbRegWrite  (wbRegWrite),
        .forwardA    (forwardA),
        .forwardB    (forwardB)
    );

    exStage ex_i (
        .pc         (exPc),
        .imm        (exImm),
        .rd1        (exRd1),
        .rd2        (exRd2),
        .memResult  (memResult),
        .wbData     (wbData),
        .aluSrc     (exAluSrc),
        .aluControl (exAluControl),
        .forwardA   (forwardA),
        .forwardB   (forwardB),
        .result     (exResult),
        .zero       (exZero),
        .tAddr      (exTAddr),
        .storeData  (exStoreData)
    );

endmodule

//--- src/exCore_params.svh
`ifndef EXCORE_PARAMS_SVH
`define EXCORE_PARAMS_SVH

// Data path and register file geometry
`define XLEN        32
`define REG_COUNT   32
`define REG_ADDR_W  5

// ALU operation codes
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_XOR     4'd4
`define ALU_SLL     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_SLT     4'd8

// Operand source picked by the forwarding unit
`define FWD_REG     2'b00
`define FWD_WB      2'b01
`define FWD_MEM     2'b10

`endif

//--- src/exStage.sv
`timescale 1ns/1ps
`include "exCore_params.svh"

module exStage import isaPkg::*, pipePkg::*; (
    input  word   pc,
    input  word   imm,
    input  word   rd1,
    input  word   rd2,
    input  word   memResult,
    input  word   wbData,
    input  logic  aluSrc,
    input  aluOp  aluControl,
    input  fwdSel forwardA,
    input  fwdSel forwardB,
    output word   result,
    output logic  zero,
    output word   tAddr,
    output word   storeData
);

    word opA;
    word fwdB;
    word opB;

    // Same three-way pick for both operands
    function automatic word fwdMux(input fwdSel sel, input word regValue);
        word value;
        case (sel)
            `FWD_MEM: value = memResult;
            `FWD_WB:  value = wbData;
            default:  value = regValue;
        endcase
        return value;
    endfunction

    assign opA  = fwdMux(forwardA, rd1);
    assign fwdB = fwdMux(forwardB, rd2);

    // Immediate replaces the register operand
    assign opB = aluSrc ? imm : fwdB;

    alu alu_i (
        .a          (opA),
        .b          (opB),
        .aluControl (aluControl),
        .result     (result),
        .zero       (zero)
    );

    // Branch target, immediate is in half-word units
    assign tAddr     = pc + (imm << 1);
    assign storeData = fwdB;

endmodule

//--- src/forwardingUnit.sv
`timescale 1ns/1ps
`include "exCore_params.svh"

module forwardingUnit import isaPkg::*, pipePkg::*; (
    input  regAddr exRs1,
    input  regAddr exRs2,
    input  regAddr memRd,
    input  regAddr wbRd,
    input  logic   memRegWrite,
    input  logic   wbRegWrite,
    output fwdSel  forwardA,
    output fwdSel  forwardB
);

    // EX/MEM holds the newer value, so it is checked first
    function automatic fwdSel pickSource(input regAddr src);
        fwdSel sel;
        if (memRegWrite && (memRd != '0) && (memRd == src)) begin
            sel = `FWD_MEM;
        end else if (wbRegWrite && (wbRd != '0) && (wbRd == src)) begin
            sel = `FWD_WB;
        end else begin
            sel = `FWD_REG;
        end
        return sel;
    endfunction

    assign forwardA = pickSource(exRs1);
    assign forwardB = pickSource(exRs2);

endmodule

//--- src/isaPkg.sv
`include "exCore_params.svh"

package isaPkg;

    // Data word, also used for addresses and immediates
    typedef logic [`XLEN-1:0] word;

    // Architectural register number
    typedef logic [`REG_ADDR_W-1:0] regAddr;

    // ALU operation, codes are the ALU_* macros
    typedef logic [3:0] aluOp;

endpackage

//--- src/pipePkg.sv
package pipePkg;

    // Operand source for one ALU input, codes are the FWD_* macros
    typedef logic [1:0] fwdSel;

endpackage

//--- src/pipeRegs.sv
`timescale 1ns/1ps

module pipeRegs import isaPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   issue,
    input  regAddr rs1,
    input  regAddr rs2,
    input  regAddr rd,
    input  word    imm,
    input  word    pc,
    input  aluOp   aluControl,
    input  logic   aluSrc,
    input  logic   regWrite,
    input  word    rdData1,
    input  word    rdData2,
    input  word    exResult,
    input  logic   exZero,
    input  word    exTAddr,
    input  word    exStoreData,
    output regAddr exRs1,
    output regAddr exRs2,
    output word    exImm,
    output word    exPc,
    output word    exRd1,
    output word    exRd2,
    output aluOp   exAluControl,
    output logic   exAluSrc,
    output regAddr memRd,
    output logic   memRegWrite,
    output word    memResult,
    output logic   wbValid,
    output regAddr wbRd,
    output logic   wbRegWrite,
    output word    wbData,
    output logic   wbZero,
    output word    wbTAddr
);

    logic   exValid;
    logic   exWrEn;
    regAddr exRdAddr;
    logic   memValid;
    logic   memWrEn;
    logic   memZero;
    word    memTAddr;
    // Kept for a later data memory stage
    word    memStoreData;
    logic   wbWrEn;

    // Valid bits and write enables
    always_ff @(posedge clk) begin
        if (rst) begin
            exValid  <= 1'b0;
            exWrEn   <= 1'b0;
            memValid <= 1'b0;
            memWrEn  <= 1'b0;
            wbValid  <= 1'b0;
            wbWrEn   <= 1'b0;
        end else begin
            exValid  <= issue;
            exWrEn   <= regWrite;
            memValid <= exValid;
            memWrEn  <= exWrEn;
            wbValid  <= memValid;
            wbWrEn   <= memWrEn;
        end
    end

    // Payload moves every cycle, valid decides whether it counts
    always_ff @(posedge clk) begin
        exRs1        <= rs1;
        exRs2        <= rs2;
        exRdAddr     <= rd;
        exImm        <= imm;
        exPc         <= pc;
        exRd1        <= rdData1;
        exRd2        <= rdData2;
        exAluControl <= aluControl;
        exAluSrc     <= aluSrc;

        memRd        <= exRdAddr;
        memResult    <= exResult;
        memZero      <= exZero;
        memTAddr     <= exTAddr;
        memStoreData <= exStoreData;

        // MEM has no memory yet, values pass straight through
        wbRd         <= memRd;
        wbData       <= memResult;
        wbZero       <= memZero;
        wbTAddr      <= memTAddr;
    end

    // A bubble never writes or forwards
    assign memRegWrite = memValid & memWrEn;
    assign wbRegWrite  = wbValid & wbWrEn;

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps
`include "exCore_params.svh"

module regFile import isaPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  regAddr rdAddr1,
    input  regAddr rdAddr2,
    input  logic   wrEn,
    input  regAddr wrAddr,
    input  word    wrData,
    output word    rdData1,
    output word    rdData2
);

    word regs [`REG_COUNT];

    // x0 reads as zero, a same-cycle write is bypassed to the reader
    function automatic word readPort(input regAddr addr);
        word value;
        if (addr == '0) begin
            value = '0;
        end else if (wrEn && (wrAddr == addr)) begin
            value = wrData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdData1 = readPort(rdAddr1);
    assign rdData2 = readPort(rdAddr2);

endmodule

//--- tb/exCoreChecker.sv
`timescale 1ns/1ps
`include "exCore_params.svh"

module exCoreChecker import isaPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   issue,
    input  regAddr rs1,
    input  regAddr rs2,
    input  regAddr rd,
    input  word    imm,
    input  word    pc,
    input  aluOp   aluControl,
    input  logic   aluSrc,
    input  logic   regWrite,
    input  logic   wbValid,
    input  regAddr wbRd,
    input  word    wbData,
    input  logic   wbZero,
    input  word    wbTAddr,
    output int     checkedCount,
    output int     errorCount,
    output int     pendingCount
);

    // Three register stages between the issue sample and the write-back sample
    localparam int WB_DELAY = 3;

    typedef struct packed {
        regAddr rd;
        word    data;
        logic   zero;
        word    tAddr;
        int     cycle;
        int     idx;
    } wbExpect;

    word     modelRegs [`REG_COUNT];
    wbExpect expQ [$];
    int      cycle = 0;
    int      issueIdx = 0;
    int      checks = 0;
    int      errors = 0;
    int      pending = 0;

    assign checkedCount = checks;
    assign errorCount   = errors;
    assign pendingCount = pending;

    // Reference ALU, shifts take b[4:0], SLT is signed
    function automatic word modelAlu(input aluOp op, input word a, input word b);
        case (op)
            `ALU_ADD: return a + b;
            `ALU_SUB: return a - b;
            `ALU_AND: return a & b;
            `ALU_OR:  return a | b;
            `ALU_XOR: return a ^ b;
            `ALU_SLL: return a << b[4:0];
            `ALU_SRL: return a >> b[4:0];
            `ALU_SRA: return word'($signed(a) >>> b[4:0]);
            `ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  return '0;
        endcase
    endfunction

    function automatic bit sameValue(input string name, input string field,
                                     input word expected, input word actual);
        if (expected !== actual) begin
            $display("ERR %s %s expected 0x%08h actual 0x%08h", name, field, expected, actual);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // In-order execution, x0 is never written so it always reads zero
    task automatic runModel();
        word     a;
        word     b;
        word     res;
        wbExpect e;
        a   = modelRegs[rs1];
        b   = aluSrc ? imm : modelRegs[rs2];
        res = modelAlu(aluControl, a, b);
        if (regWrite && (rd != '0)) begin
            modelRegs[rd] = res;
        end
        e.rd    = rd;
        e.data  = res;
        e.zero  = (res == '0);
        e.tAddr = pc + (imm << 1);
        e.cycle = cycle;
        e.idx   = issueIdx;
        issueIdx++;
        expQ.push_back(e);
    endtask

    task automatic checkWriteBack();
        wbExpect e;
        string   name;
        bit      ok;
        if (wbValid === 1'b1) begin
            if (expQ.size() == 0) begin
                $display("Write-back to x%0d at cycle %0d with no instruction in flight",
                         wbRd, cycle);
                errors++;
            end else begin
                e    = expQ.pop_front();
                name = $sformatf("instr%0d", e.idx);
                ok   = 1'b1;
                ok   = ok & sameValue(name, "rd", word'(e.rd), word'(wbRd));
                ok   = ok & sameValue(name, "data", e.data, wbData);
                ok   = ok & sameValue(name, "zero", word'(e.zero), word'(wbZero));
                ok   = ok & sameValue(name, "tAddr", e.tAddr, wbTAddr);
                if (cycle != e.cycle + WB_DELAY) begin
                    $display("ERR %s latency expected %0d actual %0d cycles", name,
                             WB_DELAY, cycle - e.cycle);
                    ok = 1'b0;
                end
                checks++;
                if (ok) begin
                    $display("PASS %s x%0d = 0x%08h", name, wbRd, wbData);
                end else begin
                    errors++;
                end
            end
        end else if (wbValid !== 1'b0) begin
            $display("wbValid is unknown at cycle %0d", cycle);
            errors++;
        end
    endtask

    // Anything past its write-back slot was dropped by the pipeline
    task automatic checkOverdue();
        wbExpect e;
        while ((expQ.size() > 0) && (expQ[0].cycle + WB_DELAY < cycle)) begin
            e = expQ.pop_front();
            $display("instr%0d never wrote back", e.idx);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                modelRegs[i] = '0;
            end
        end else begin
            checkWriteBack();
            checkOverdue();
            if (issue === 1'b1) begin
                runModel();
            end
        end
        pending = expQ.size();
    end

endmodule

//--- tb/exCoreTb.sv
`timescale 1ns/1ps
`include "exCore_params.svh"

module exCoreTb import isaPkg::*; ();

    localparam int NUM_SLOTS    = 400;
    localparam int RESET_CYCLES = 4;
    localparam int LATENCY      = 3;
    localparam int TIMEOUT      = RESET_CYCLES + NUM_SLOTS + LATENCY + 20;
    localparam int unsigned SEED = 32'hff56;

    logic   clk = 1'b0;
    logic   rst;
    logic   issue;
    regAddr rs1;
    regAddr rs2;
    regAddr rd;
    word    imm;
    word    pc;
    aluOp   aluControl;
    logic   aluSrc;
    logic   regWrite;
    logic   wbValid;
    regAddr wbRd;
    word    wbData;
    logic   wbZero;
    word    wbTAddr;
    int     checkedCount;
    int     errorCount;
    int     pendingCount;
    int     issuedCount = 0;
    int     cycles = 0;

    always #20 clk = ~clk;

    exCore dut_i (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .imm        (imm),
        .pc         (pc),
        .aluControl (aluControl),
        .aluSrc     (aluSrc),
        .regWrite   (regWrite),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .wbZero     (wbZero),
        .wbTAddr    (wbTAddr)
    );

    exCoreChecker chk_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .imm          (imm),
        .pc           (pc),
        .aluControl   (aluControl),
        .aluSrc       (aluSrc),
        .regWrite     (regWrite),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbData       (wbData),
        .wbZero       (wbZero),
        .wbTAddr      (wbTAddr),
        .checkedCount (checkedCount),
        .errorCount   (errorCount),
        .pendingCount (pendingCount)
    );

    function automatic aluOp randomOp();
        case ($urandom % 9)
            0:       return `ALU_ADD;
            1:       return `ALU_SUB;
            2:       return `ALU_AND;
            3:       return `ALU_OR;
            4:       return `ALU_XOR;
            5:       return `ALU_SLL;
            6:       return `ALU_SRL;
            7:       return `ALU_SRA;
            default: return `ALU_SLT;
        endcase
    endfunction

    // Only x0..x7 so that most instructions depend on recent ones
    task automatic driveInstr();
        issue      = (($urandom % 4) != 0);
        rs1        = regAddr'($urandom % 8);
        rs2        = regAddr'($urandom % 8);
        rd         = regAddr'($urandom % 8);
        aluControl = randomOp();
        aluSrc     = (($urandom % 3) == 0);
        regWrite   = (($urandom % 8) != 0);
        if (($urandom % 2) != 0) begin
            imm = $urandom;
        end else begin
            imm = ($urandom % 64) - 32;
        end
        pc = pc + 4;
        if (issue) begin
            issuedCount++;
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the pipeline stopped writing back", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        issue      = 1'b0;
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        imm        = '0;
        pc         = 32'h0000_1000;
        aluControl = `ALU_ADD;
        aluSrc     = 1'b0;
        regWrite   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            driveInstr();
            @(negedge clk);
        end
        issue = 1'b0;
        while (pendingCount != 0) begin
            @(negedge clk);
        end
        // A few idle cycles to catch a stray write-back
        repeat (2) @(negedge clk);
        $display("Totals: %0d issued, %0d checked, %0d errors",
                 issuedCount, checkedCount, errorCount);
        if ((errorCount == 0) && (checkedCount == issuedCount)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
